// File: src.f
+incdir+dv
common/sgmii_rx_pkg.sv
design/symbol_gearbox.sv
decoder/decode_6b_5b.sv
decoder/decode_4b_3b.sv
decoder/decode_8b10b.sv
design/comma_lock.sv
design/sgmii_rx_top.sv
dv/sgmii_rx_tb.sv

// File: Makefile
.PHONY: all run lint clean

SOURCES := src.f $(wildcard common/*.sv design/*.sv decoder/*.sv dv/*.sv dv/*.svh)

all: run

obj_dir/sim: $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f src.f --top-module sgmii_rx_tb -o sim

run: obj_dir/sim
	./obj_dir/sim | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f src.f --top-module sgmii_rx_top

clean:
	rm -rf obj_dir sim.log

// File: dv/sgmii_rx_model.svh
`ifndef SGMII_RX_MODEL_SVH
`define SGMII_RX_MODEL_SVH

//////////////////////////////
// Reference 8b/10b encoder

// D.0 to D.31 six-bit forms for negative disparity, abcdei
function automatic logic [5:0] six_form(input logic [4:0] x);
	logic [5:0] forms [32];
	forms = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	return forms[x];
endfunction

// x.0 to x.7 four-bit forms for negative disparity, fghj
function automatic logic [3:0] four_form(input logic [2:0] y);
	logic [3:0] forms [8];
	forms = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
	return forms[y];
endfunction

function automatic int count_ones(input logic [9:0] v);
	int n;
	n = 0;
	for (int i = 0; i < 10; i++)
		n += int'(v[i]);
	return n;
endfunction

// New running disparity in bit 10, code abcdei fghj below it
function automatic logic [10:0] encode_symbol(input logic [7:0] b, input logic k,
		input logic rd);
	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] c6;
	logic [3:0] c4;
	logic [9:0] code;
	logic rd_mid;
	logic rd_out;
	logic alt7;
	x = b[4:0];
	y = b[7:5];
	if (k) begin
		// K28 built in its negative form, whole code flipped below
		c6 = k28_six_neg;
		rd_mid = 1'b1;
	end else begin
		c6 = six_form(x);
		// Unbalanced blocks and D.7 swap with disparity
		if (rd && (count_ones({4'b0, c6}) != 3 || x == 5'd7))
			c6 = ~c6;
		rd_mid = rd;
		if (count_ones({4'b0, c6}) != 3)
			rd_mid = count_ones({4'b0, c6}) > 3;
	end
	// Alternate x.7 keeps runs under six
	alt7 = (y == 3'd7) && (k || (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20))
		|| (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
	c4 = alt7 ? 4'b0111 : four_form(y);
	if (rd_mid && (count_ones({6'b0, c4}) != 2 || y == 3'd3))
		c4 = ~c4;
	code = {c6, c4};
	if (k && rd)
		code = ~code;
	rd_out = rd;
	if (count_ones(code) != 5)
		rd_out = count_ones(code) > 5;
	return {rd_out, code};
endfunction

//////////////////////////////
// Beat splitter

// Count in bits 7:5, oldest bit highest in the used part of 4:0
function automatic logic [7:0] next_beat();
	int want;
	logic [4:0] data;
	logic [2:0] n;
	want = $urandom_range(5, 2);
	data = '0;
	n = '0;
	while (int'(n) < want && line_bits.size() > 0) begin
		data = {data[3:0], line_bits.pop_front()};
		n = n + 1'b1;
	end
	return {n, data};
endfunction

`endif

// File: dv/sgmii_rx_tb.sv
module sgmii_rx_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import sgmii_rx_pkg::*;

	logic clk_312p5mhz;
	logic rst_n;
	logic [4:0] rx_data;
	logic [2:0] rx_data_count;
	logic [7:0] rx_byte;
	logic rx_byte_valid;
	logic rx_is_ctl;
	logic rx_symbol_err;
	logic rx_disparity_err;
	logic link_up;

	// Line bits with the oldest first
	bit line_bits[$];
	// Expected symbols after the preamble
	// Kind 0 is clean, 1 an invalid code and 2 the wrong disparity
	logic [7:0] exp_byte[$];
	bit exp_ctl[$];
	int exp_kind[$];
	int exp_test[$];

	logic tx_rd;
	bit locked_once;
	bit aligned;
	bit saw_unlock;
	bit finished;
	int cur_test;
	int symbol_total;
	int checks[1:6];
	int errors[1:6];
	string test_name[1:6];

	`include "sgmii_rx_model.svh"

	sgmii_rx_top sgmii_rx_top_i (
		.clk_312p5mhz     (clk_312p5mhz),
		.rst_n            (rst_n),
		.rx_data          (rx_data),
		.rx_data_count    (rx_data_count),
		.rx_byte          (rx_byte),
		.rx_byte_valid    (rx_byte_valid),
		.rx_is_ctl        (rx_is_ctl),
		.rx_symbol_err    (rx_symbol_err),
		.rx_disparity_err (rx_disparity_err),
		.link_up          (link_up)
	);

	always #100 clk_312p5mhz = ~clk_312p5mhz;

	// Encode onto the line with optional corruption
	task automatic queue_symbol(input logic [7:0] b, input bit k, input int kind,
			input int test_id);
		logic [10:0] enc;
		enc = encode_symbol(b, k, (kind == 2) ? !tx_rd : tx_rd);
		tx_rd = enc[10];
		if (kind == 1) begin
			// Forcing fghj to 0000 leaves the line negative
			enc[3:0] = 4'b0000;
			tx_rd = 1'b0;
		end
		for (int i = 9; i >= 0; i--)
			line_bits.push_back(enc[i]);
		symbol_total++;
		if (test_id > 1) begin
			exp_byte.push_back(b);
			exp_ctl.push_back(k);
			exp_kind.push_back(kind);
			exp_test.push_back(test_id);
		end
	endtask

	task automatic report_test(input int t);
		$display("Test %0d %s: %s, %0d checks, %0d errors", t, test_name[t],
			(errors[t] == 0) ? "ok" : "FAIL", checks[t], errors[t]);
	endtask

	task automatic check_output();
		logic [7:0] b;
		bit ctl;
		int kind;
		int t;
		if (exp_byte.size() == 0) begin
			$display("Decoded symbol at %0t ns with nothing left to compare", $time);
			errors[6]++;
			return;
		end
		b = exp_byte.pop_front();
		ctl = exp_ctl.pop_front();
		kind = exp_kind.pop_front();
		t = exp_test.pop_front();
		if (t != cur_test) begin
			report_test(cur_test);
			cur_test = t;
		end
		checks[t]++;
		// An invalid code leaves byte and disparity open
		if (kind != 1) begin
			assert (rx_byte == b) else begin
				$display("MISMATCH %0t ns rx_byte expected %02h actual %02h", $time, b, rx_byte);
				errors[t]++;
			end
			assert (rx_is_ctl == ctl) else begin
				$display("MISMATCH %0t ns rx_is_ctl expected %0b actual %0b", $time, ctl,
					rx_is_ctl);
				errors[t]++;
			end
			assert (rx_disparity_err == (kind == 2)) else begin
				$display("MISMATCH %0t ns rx_disparity_err expected %0b actual %0b", $time,
					kind == 2, rx_disparity_err);
				errors[t]++;
			end
		end
		assert (rx_symbol_err == (kind == 1)) else begin
			$display("MISMATCH %0t ns rx_symbol_err expected %0b actual %0b", $time,
				kind == 1, rx_symbol_err);
			errors[t]++;
		end
		if (t < 6) begin
			assert (link_up) else begin
				$display("link_up low during test %0d at %0t ns", t, $time);
				errors[t]++;
			end
		end
		if (exp_byte.size() == 0) begin
			assert (saw_unlock) else begin
				$display("link_up never dropped after four invalid symbols");
				errors[6]++;
			end
			assert (link_up) else begin
				$display("link_up did not come back after commas");
				errors[6]++;
			end
			report_test(6);
			finished = 1'b1;
		end
	endtask

	//////////////////////////////
	// Beat driver
	always @(posedge clk_312p5mhz) begin
		logic [7:0] beat;
		if (rst_n) begin
			beat = next_beat();
			rx_data_count <= beat[7:5];
			rx_data <= beat[4:0];
		end
	end

	//////////////////////////////
	// Compare on the falling edge
	always @(negedge clk_312p5mhz) begin
		bit clean;
		if (rst_n && link_up && !locked_once) begin
			locked_once = 1'b1;
			checks[1]++;
			report_test(1);
		end
		if (aligned && !link_up)
			saw_unlock = 1'b1;
		if (rst_n && rx_byte_valid && locked_once) begin
			clean = rx_is_ctl && rx_byte == comma_byte && !rx_symbol_err && !rx_disparity_err;
			// Skip rest of preamble commas
			if (!aligned && !clean)
				aligned = 1'b1;
			if (aligned && !finished)
				check_output();
		end
	end

	//////////////////////////////
	// Watchdog allows five cycles per symbol at two-bit beats
	initial begin
		int limit;
		wait (rst_n);
		limit = symbol_total * 5 + 200;
		repeat (limit) @(posedge clk_312p5mhz);
		if (!finished) begin
			$display("Timeout after %0d cycles, lock %0b, %0d symbols not seen", limit,
				locked_once, exp_byte.size());
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int total_checks;
		int total_errors;
		void'($urandom(32'hbb5f));
		clk_312p5mhz = 1'b0;
		rst_n = 1'b0;
		rx_data = '0;
		rx_data_count = '0;
		tx_rd = 1'b0;
		cur_test = 2;
		test_name = '{"lock acquisition", "data path", "control symbols", "invalid code",
			"disparity error", "loss of lock"};
		// Unknown bit offset ahead of the first symbol
		repeat ($urandom_range(9, 1))
			line_bits.push_back(1'($urandom));
		// Enough commas for nine slips
		repeat (200)
			queue_symbol(comma_byte, 1'b1, 0, 1);
		repeat (200)
			queue_symbol(8'($urandom), 1'b0, 0, 2);
		// Pairs cover both disparities
		repeat (3) begin
			queue_symbol(comma_byte, 1'b1, 0, 3);
			queue_symbol(comma_byte, 1'b1, 0, 3);
			queue_symbol(8'h3c, 1'b1, 0, 3);
			queue_symbol(8'h3c, 1'b1, 0, 3);
		end
		repeat (4)
			queue_symbol(8'($urandom), 1'b0, 0, 4);
		queue_symbol(8'($urandom), 1'b0, 1, 4);
		repeat (4)
			queue_symbol(8'($urandom), 1'b0, 0, 4);
		repeat (2)
			queue_symbol(comma_byte, 1'b1, 0, 4);
		// D.0.0 has both halves unbalanced
		repeat (4)
			queue_symbol(8'($urandom), 1'b0, 0, 5);
		queue_symbol(8'h00, 1'b0, 2, 5);
		repeat (4)
			queue_symbol(8'($urandom), 1'b0, 0, 5);
		repeat (2)
			queue_symbol(comma_byte, 1'b1, 0, 5);
		repeat (2)
			queue_symbol(8'($urandom), 1'b0, 0, 6);
		repeat (4)
			queue_symbol(8'($urandom), 1'b0, 1, 6);
		repeat (6)
			queue_symbol(comma_byte, 1'b1, 0, 6);
		repeat (4)
			queue_symbol(8'($urandom), 1'b0, 0, 6);
		repeat (3) @(posedge clk_312p5mhz);
		rst_n <= 1'b1;
		wait (finished);
		total_checks = 0;
		total_errors = 0;
		for (int t = 1; t <= 6; t++) begin
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("Summary: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: design/sgmii_rx_top.sv
module sgmii_rx_top (
	input  logic                                      clk_312p5mhz,
	input  logic                                      rst_n,
	input  logic [sgmii_rx_pkg::beat_width-1:0]       rx_data,
	input  logic [sgmii_rx_pkg::beat_count_width-1:0] rx_data_count,
	output logic [7:0]                                rx_byte,
	output logic                                      rx_byte_valid,
	output logic                                      rx_is_ctl,
	output logic                                      rx_symbol_err,
	output logic                                      rx_disparity_err,
	output logic                                      link_up
);
	import sgmii_rx_pkg::*;

	logic [symbol_width-1:0] symbol;
	logic symbol_valid;
	logic bitslip;

	//////////////////////////////
	// Variable rate bits to symbols
	symbol_gearbox gearbox_i (
		.clk_312p5mhz  (clk_312p5mhz),
		.rst_n         (rst_n),
		.rx_data       (rx_data),
		.rx_data_count (rx_data_count),
		.bitslip       (bitslip),
		.symbol        (symbol),
		.symbol_valid  (symbol_valid)
	);

	//////////////////////////////
	// 8b/10b decode
	decode_8b10b decoder_i (
		.clk_312p5mhz  (clk_312p5mhz),
		.rst_n         (rst_n),
		.symbol        (symbol),
		.symbol_valid  (symbol_valid),
		.data_byte     (rx_byte),
		.byte_valid    (rx_byte_valid),
		.is_ctl        (rx_is_ctl),
		.symbol_err    (rx_symbol_err),
		.disparity_err (rx_disparity_err)
	);

	// Lock monitor steers gearbox alignment
	comma_lock lock_i (
		.clk_312p5mhz  (clk_312p5mhz),
		.rst_n         (rst_n),
		.data_byte     (rx_byte),
		.byte_valid    (rx_byte_valid),
		.is_ctl        (rx_is_ctl),
		.symbol_err    (rx_symbol_err),
		.disparity_err (rx_disparity_err),
		.bitslip       (bitslip),
		.link_up       (link_up)
	);

endmodule

// File: design/comma_lock.sv
module comma_lock (
	input  logic       clk_312p5mhz,
	input  logic       rst_n,
	input  logic [7:0] data_byte,
	input  logic       byte_valid,
	input  logic       is_ctl,
	input  logic       symbol_err,
	input  logic       disparity_err,
	output logic       bitslip,
	output logic       link_up
);
	import sgmii_rx_pkg::*;

	logic sym_bad;
	logic clean_comma;
	logic [search_count_width-1:0] search_count;
	logic [lock_count_width-1:0] comma_count;
	logic [error_count_width-1:0] error_count;

	assign sym_bad = symbol_err || disparity_err;
	// K28.5 with no error flag
	assign clean_comma = is_ctl && (data_byte == comma_byte) && !sym_bad;

	//////////////////////////////
	// Search and lock FSM

	always_ff @(posedge clk_312p5mhz or negedge rst_n) begin
		if (!rst_n) begin
			bitslip <= 1'b0;
			link_up <= 1'b0;
			search_count <= '0;
			comma_count <= '0;
			error_count <= '0;
		end else begin
			bitslip <= 1'b0;
			if (byte_valid && !link_up) begin
				if (clean_comma) begin
					// Alignment looks right so keep counting commas
					search_count <= '0;
					if (comma_count == lock_comma_count - 1) begin
						link_up <= 1'b1;
						comma_count <= '0;
						error_count <= '0;
					end else begin
						comma_count <= comma_count + 1'b1;
					end
				end else begin
					// Bad symbol spoils the comma run
					if (sym_bad)
						comma_count <= '0;
					// No comma for too long so slip one bit
					if (search_count == comma_search_limit - 1) begin
						bitslip <= 1'b1;
						search_count <= '0;
						comma_count <= '0;
					end else begin
						search_count <= search_count + 1'b1;
					end
				end
			end else if (byte_valid) begin
				// While locked a clean comma forgives earlier errors
				if (clean_comma) begin
					error_count <= '0;
				end else if (sym_bad) begin
					if (error_count == unlock_error_count - 1) begin
						link_up <= 1'b0;
						error_count <= '0;
						search_count <= '0;
						comma_count <= '0;
					end else begin
						error_count <= error_count + 1'b1;
					end
				end
			end
		end
	end

	// Decoder flags only come with a decoded byte
	flags_with_byte : assert property (@(posedge clk_312p5mhz) disable iff (!rst_n)
		(symbol_err || disparity_err) |-> byte_valid);

endmodule

// File: decoder/decode_8b10b.sv
module decode_8b10b (
	input  logic                                  clk_312p5mhz,
	input  logic                                  rst_n,
	input  logic [sgmii_rx_pkg::symbol_width-1:0] symbol,
	input  logic                                  symbol_valid,
	output logic [7:0]                            data_byte,
	output logic                                  byte_valid,
	output logic                                  is_ctl,
	output logic                                  symbol_err,
	output logic                                  disparity_err
);
	import sgmii_rx_pkg::*;

	logic [4:0] bits5;
	logic valid6;
	logic [1:0] class6;
	logic is_k28;
	logic [2:0] bits3;
	logic valid4;
	logic [1:0] class4;
	logic [2:0] bits3_fixed;

	// Running disparity is high when positive
	logic rd_pos;
	logic rd_mid;
	logic rd_next;
	logic disp_bad;

	//////////////////////////////
	// Sub-block decoders

	decode_6b_5b dec_6b_i (
		.code       (symbol[symbol_width-1 -: 6]),
		.bits       (bits5),
		.valid      (valid6),
		.disp_class (class6),
		.is_k28     (is_k28)
	);

	decode_4b_3b dec_4b_i (
		.code       (symbol[3:0]),
		.bits       (bits3),
		.valid      (valid4),
		.disp_class (class4)
	);

	// Positive K28 complements fghj
	// So 1 and 6 trade places as do 2 and 5
	always_comb begin
		bits3_fixed = bits3;
		if (symbol[symbol_width-1 -: 6] == k28_six_pos) begin
			case (bits3)
				3'd1: bits3_fixed = 3'd6;
				3'd6: bits3_fixed = 3'd1;
				3'd2: bits3_fixed = 3'd5;
				3'd5: bits3_fixed = 3'd2;
				default: bits3_fixed = bits3;
			endcase
		end
	end

	//////////////////////////////
	// Running disparity check

	// Unbalanced block must oppose current disparity
	// Tracking follows the line even on a violation
	always_comb begin
		disp_bad = 1'b0;
		rd_mid = rd_pos;
		if (class6 == disp_pos) begin
			disp_bad = rd_pos;
			rd_mid = 1'b1;
		end else if (class6 == disp_neg) begin
			disp_bad = !rd_pos;
			rd_mid = 1'b0;
		end
		rd_next = rd_mid;
		if (class4 == disp_pos) begin
			disp_bad = disp_bad | rd_mid;
			rd_next = 1'b1;
		end else if (class4 == disp_neg) begin
			disp_bad = disp_bad | !rd_mid;
			rd_next = 1'b0;
		end
	end

	always_ff @(posedge clk_312p5mhz or negedge rst_n) begin
		if (!rst_n) begin
			rd_pos <= 1'b0;
			byte_valid <= 1'b0;
			symbol_err <= 1'b0;
			disparity_err <= 1'b0;
		end else begin
			byte_valid <= symbol_valid;
			symbol_err <= symbol_valid && !(valid6 && valid4);
			disparity_err <= symbol_valid && disp_bad;
			if (symbol_valid)
				rd_pos <= rd_next;
		end
	end

	// Decoded byte is HGF then EDCBA
	always_ff @(posedge clk_312p5mhz) begin
		if (symbol_valid) begin
			data_byte <= {bits3_fixed, bits5};
			is_ctl <= is_k28;
		end
	end

	// Ten bits take at least two beats of five
	symbol_strobe_spaced : assert property (@(posedge clk_312p5mhz) disable iff (!rst_n)
		symbol_valid |=> !symbol_valid);

endmodule

// File: decoder/decode_4b_3b.sv
module decode_4b_3b (
	input  logic [3:0] code,
	output logic [2:0] bits,
	output logic       valid,
	output logic [1:0] disp_class
);
	import sgmii_rx_pkg::*;

	logic [2:0] ones;

	// Code is fghj, f in bit 3
	always_comb begin
		valid = 1'b1;
		case (code)
			4'b1011, 4'b0100: bits = 3'd0;
			4'b1001: bits = 3'd1;
			4'b0101: bits = 3'd2;
			4'b1100, 4'b0011: bits = 3'd3;
			4'b1101, 4'b0010: bits = 3'd4;
			4'b1010: bits = 3'd5;
			4'b0110: bits = 3'd6;
			// Primary and alternate x.7
			4'b1110, 4'b0001: bits = 3'd7;
			4'b0111, 4'b1000: bits = 3'd7;
			// Only 0000 and 1111 land here
			default: begin
				bits = 3'd0;
				valid = 1'b0;
			end
		endcase
	end

	always_comb begin
		ones = '0;
		for (int i = 0; i < 4; i++)
			ones = ones + 3'(code[i]);
	end

	// Two ones is balanced
	always_comb begin
		if (ones > 3'd2)
			disp_class = disp_pos;
		else if (ones < 3'd2)
			disp_class = disp_neg;
		else
			disp_class = disp_neutral;
	end

endmodule

// File: decoder/decode_6b_5b.sv
module decode_6b_5b (
	input  logic [5:0] code,
	output logic [4:0] bits,
	output logic       valid,
	output logic [1:0] disp_class,
	output logic       is_k28
);
	import sgmii_rx_pkg::*;

	logic [2:0] ones;

	// Code is abcdei, a in bit 5
	// Both disparity forms listed where they differ
	always_comb begin
		valid = 1'b1;
		case (code)
			6'b100111, 6'b011000: bits = 5'd0;
			6'b011101, 6'b100010: bits = 5'd1;
			6'b101101, 6'b010010: bits = 5'd2;
			6'b110001: bits = 5'd3;
			6'b110101, 6'b001010: bits = 5'd4;
			6'b101001: bits = 5'd5;
			6'b011001: bits = 5'd6;
			6'b111000, 6'b000111: bits = 5'd7;
			6'b111001, 6'b000110: bits = 5'd8;
			6'b100101: bits = 5'd9;
			6'b010101: bits = 5'd10;
			6'b110100: bits = 5'd11;
			6'b001101: bits = 5'd12;
			6'b101100: bits = 5'd13;
			6'b011100: bits = 5'd14;
			6'b010111, 6'b101000: bits = 5'd15;
			6'b011011, 6'b100100: bits = 5'd16;
			6'b100011: bits = 5'd17;
			6'b010011: bits = 5'd18;
			6'b110010: bits = 5'd19;
			6'b001011: bits = 5'd20;
			6'b101010: bits = 5'd21;
			6'b011010: bits = 5'd22;
			6'b111010, 6'b000101: bits = 5'd23;
			6'b110011, 6'b001100: bits = 5'd24;
			6'b100110: bits = 5'd25;
			6'b010110: bits = 5'd26;
			6'b110110, 6'b001001: bits = 5'd27;
			6'b001110: bits = 5'd28;
			6'b101110, 6'b010001: bits = 5'd29;
			6'b011110, 6'b100001: bits = 5'd30;
			6'b101011, 6'b010100: bits = 5'd31;
			// Control form of 28
			k28_six_neg, k28_six_pos: bits = 5'd28;
			default: begin
				bits = 5'd0;
				valid = 1'b0;
			end
		endcase
	end

	// Ones count sets the class
	always_comb begin
		ones = '0;
		for (int i = 0; i < 6; i++)
			ones = ones + 3'(code[i]);
	end

	always_comb begin
		if (ones > 3'd3)
			disp_class = disp_pos;
		else if (ones < 3'd3)
			disp_class = disp_neg;
		else
			disp_class = disp_neutral;
	end

	assign is_k28 = (code == k28_six_neg) || (code == k28_six_pos);

endmodule

// File: design/symbol_gearbox.sv
module symbol_gearbox (
	input  logic                                      clk_312p5mhz,
	input  logic                                      rst_n,
	input  logic [sgmii_rx_pkg::beat_width-1:0]       rx_data,
	input  logic [sgmii_rx_pkg::beat_count_width-1:0] rx_data_count,
	input  logic                                      bitslip,
	output logic [sgmii_rx_pkg::symbol_width-1:0]     symbol,
	output logic                                      symbol_valid
);
	import sgmii_rx_pkg::*;

	// Oldest bit sits at the top of the valid region
	logic [buffer_width-1:0] shift_buf;
	logic [fill_width-1:0] fill;

	logic [beat_count_width-1:0] take;
	logic [buffer_width-1:0] appended;
	logic [fill_width-1:0] total;
	logic [fill_width-1:0] start;
	logic emit;

	//////////////////////////////
	// Append the new beat

	// Slip drops the oldest bit of this beat
	// Empty beat loses the slip
	always_comb begin
		take = rx_data_count;
		if (bitslip && rx_data_count != '0)
			take = rx_data_count - 1'b1;
	end

	// Shift in from the right, newest bit at bit 0
	always_comb begin
		case (take)
			3'd1: appended = {shift_buf[buffer_width-2:0], rx_data[0]};
			3'd2: appended = {shift_buf[buffer_width-3:0], rx_data[1:0]};
			3'd3: appended = {shift_buf[buffer_width-4:0], rx_data[2:0]};
			3'd4: appended = {shift_buf[buffer_width-5:0], rx_data[3:0]};
			3'd5: appended = {shift_buf[buffer_width-6:0], rx_data[4:0]};
			default: appended = shift_buf;
		endcase
	end

	// Bits held after this beat, at most 14
	assign total = fill + fill_width'(take);
	assign emit = total >= fill_width'(symbol_width);

	// Base of the oldest ten bits, also the leftover count
	assign start = total - fill_width'(symbol_width);

	//////////////////////////////
	// Emit a symbol

	always_ff @(posedge clk_312p5mhz or negedge rst_n) begin
		if (!rst_n) begin
			fill <= '0;
			symbol_valid <= 1'b0;
		end else begin
			symbol_valid <= emit;
			// Remainder of the completing beat stays
			fill <= emit ? start : total;
		end
	end

	always_ff @(posedge clk_312p5mhz) begin
		shift_buf <= appended;
		if (emit)
			symbol <= appended[start +: symbol_width];
	end

	// Recovery block never hands over more than a beat
	beat_count_legal : assert property (@(posedge clk_312p5mhz) disable iff (!rst_n)
		rx_data_count <= beat_count_width'(beat_width));

endmodule

// File: common/sgmii_rx_pkg.sv
package sgmii_rx_pkg;

	//////////////////////////////
	// Line symbol and beat sizes

	// One 8b/10b line symbol
	localparam int symbol_width = 10;

	// Most new bits per clock from the recovery block
	localparam int beat_width = 5;
	localparam int beat_count_width = 3;

	// Gearbox buffer holds a partial symbol plus one full beat
	localparam int buffer_width = 15;
	localparam int fill_width = 4;

	//////////////////////////////
	// Line code constants

	// K28.5 decoded
	localparam logic [7:0] comma_byte = 8'hbc;

	// Six-bit K28 forms as abcdei
	localparam logic [5:0] k28_six_neg = 6'b001111;
	localparam logic [5:0] k28_six_pos = 6'b110000;

	// Disparity class of one sub-block
	localparam logic [1:0] disp_neutral = 2'b00;
	localparam logic [1:0] disp_neg = 2'b01;
	localparam logic [1:0] disp_pos = 2'b10;

	//////////////////////////////
	// Lock monitor thresholds

	// Symbols without a comma before one slip
	localparam int comma_search_limit = 16;
	localparam int search_count_width = 5;

	// Clean commas to declare lock
	localparam int lock_comma_count = 3;
	localparam int lock_count_width = 2;

	// Errors while locked that drop lock
	localparam int unlock_error_count = 4;
	localparam int error_count_width = 3;

endpackage
